//--- build.f
src/div_pkg.sv
src/div_sign_ctrl.sv
src/div_core.sv
src/div_result.sv
src/div_unit.sv
tb/div_unit_checker.sv
tb/div_monitor.sv
tb/div_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module div_unit_tb \
        -o div_unit_sim \
    && ./obj_dir/div_unit_sim | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- src/div_core.sv
`timescale 1ns/1ps

module div_core import div_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,          // only seen while idle
    input  logic [DATA_W-1:0] dividend_mag,
    input  logic [DATA_W-1:0] divisor_mag,
    output logic [DATA_W-1:0] quotient,
    output logic [DATA_W-1:0] remainder,
    output logic              core_done
);

    logic                 active;
    logic [ROUND_W-1:0]   round;
    logic                 do_minus;     // subtract next when last result was positive
    logic [2*DATA_W+1:0]  scratch;      // partial remainder over dividend, two guard bits
    logic [DATA_W+1:0]    div_p;        // divisor, positive copy
    logic [DATA_W+1:0]    div_n;        // divisor, negated copy
    logic [DATA_W+1:0]    sum;
    logic                 sum_neg;

    // one adder serves both add and subtract
    assign sum     = (do_minus ? div_n : div_p) + scratch[DATA_W +: DATA_W+2];
    assign sum_neg = sum[DATA_W+1];

    // scratch is shifted left once more than the remainder
    assign remainder = scratch[DATA_W+1 +: DATA_W];

    // sequencing: load, DATA_W+1 iterations, one correction step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            round     <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= 1'b0;
            if (active) begin
                if (round == FIX_ROUND) begin
                    active    <= 1'b0;
                    core_done <= 1'b1;     // high for one cycle
                end else begin
                    round <= round + 1'b1;
                end
            end else if (start) begin
                active <= 1'b1;
                round  <= '0;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (!active) begin
            if (start) begin
                scratch  <= {{(DATA_W+2){1'b0}}, dividend_mag};
                div_p    <= {2'b00, divisor_mag};
                div_n    <= -{2'b00, divisor_mag};
                do_minus <= 1'b1;          // first step always subtracts
            end
        end else if (round != FIX_ROUND) begin
            // keep the sum and bring in the next dividend bit
            scratch  <= {sum[DATA_W:0], scratch[DATA_W-1:0], 1'b0};
            quotient <= {quotient[DATA_W-2:0], ~sum_neg};
            do_minus <= ~sum_neg;
        end else if (!do_minus) begin
            // last partial remainder negative, add the divisor back
            scratch[DATA_W+1 +: DATA_W] <= remainder + div_p[DATA_W-1:0];
        end
    end

endmodule

//--- src/div_pkg.sv
package div_pkg;

    // datapath width
    localparam int DATA_W = 32;

    // op code, bit 0 marks unsigned, bit 1 marks remainder
    localparam int OP_W = 2;

    localparam logic [OP_W-1:0] OP_DIV  = 2'b00;  // signed quotient
    localparam logic [OP_W-1:0] OP_DIVU = 2'b01;  // unsigned quotient
    localparam logic [OP_W-1:0] OP_REM  = 2'b10;  // signed remainder
    localparam logic [OP_W-1:0] OP_REMU = 2'b11;  // unsigned remainder

    // edges from the start sample to done high
    // load, DATA_W+1 iterations, correction, result register
    localparam int DIV_LATENCY = DATA_W + 3;

    // iteration counter of the core
    localparam int ROUND_W = $clog2(DATA_W + 2);

    // counter value of the correction step, the iterations run before it
    localparam logic [ROUND_W-1:0] FIX_ROUND = ROUND_W'(DATA_W + 1);

endpackage

//--- src/div_result.sv
`timescale 1ns/1ps

module div_result import div_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,          // accepted start only
    input  logic              core_done,
    input  logic [DATA_W-1:0] quotient,
    input  logic [DATA_W-1:0] remainder,
    input  logic              neg_quot,
    input  logic              neg_rem,
    input  logic              div_zero,
    input  logic              overflow,
    input  logic              sel_rem,
    input  logic [DATA_W-1:0] dividend_hold,
    output logic [DATA_W-1:0] result,
    output logic              busy,
    output logic              done
);

    logic [DATA_W-1:0] mag;
    logic              neg;
    logic [DATA_W-1:0] signed_val;
    logic [DATA_W-1:0] final_val;

    assign mag        = sel_rem ? remainder : quotient;
    assign neg        = sel_rem ? neg_rem : neg_quot;
    assign signed_val = neg ? -mag : mag;

    // architectural results of the special cases
    always_comb begin
        if (div_zero) begin
            final_val = sel_rem ? dividend_hold : '1;
        end else if (overflow) begin
            final_val = sel_rem ? '0 : {1'b1, {(DATA_W-1){1'b0}}};
        end else begin
            final_val = signed_val;
        end
    end

    // busy from the start edge until done falls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= core_done;
            if (start) begin
                busy <= 1'b1;              // back to back start in the done cycle
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // result holds until the next done
    always_ff @(posedge clk) begin
        if (core_done) begin
            result <= final_val;
        end
    end

endmodule

//--- src/div_sign_ctrl.sv
`timescale 1ns/1ps

module div_sign_ctrl import div_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,          // accepted start only
    input  logic [OP_W-1:0]   op,
    input  logic [DATA_W-1:0] dividend,
    input  logic [DATA_W-1:0] divisor,
    output logic [DATA_W-1:0] dividend_mag,   // combinational, valid with start
    output logic [DATA_W-1:0] divisor_mag,
    output logic              neg_quot,
    output logic              neg_rem,
    output logic              div_zero,
    output logic              overflow,
    output logic              sel_rem,
    output logic [DATA_W-1:0] dividend_hold
);

    logic signed_op;
    logic dividend_neg;
    logic divisor_neg;
    logic divisor_zero;
    logic signed_ovf;

    assign signed_op    = (op == OP_DIV) || (op == OP_REM);
    assign dividend_neg = signed_op & dividend[DATA_W-1];
    assign divisor_neg  = signed_op & divisor[DATA_W-1];
    assign divisor_zero = (divisor == '0);

    // most negative value over minus one
    assign signed_ovf = signed_op
                        & (dividend == {1'b1, {(DATA_W-1){1'b0}}})
                        & (divisor == '1);

    // magnitudes, the most negative value maps onto itself as unsigned 2^(W-1)
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag  = divisor_neg ? -divisor : divisor;

    // flags for the result block, held for the whole division
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            neg_quot <= 1'b0;
            neg_rem  <= 1'b0;
            div_zero <= 1'b0;
            overflow <= 1'b0;
            sel_rem  <= 1'b0;
        end else if (start) begin
            neg_quot <= (dividend_neg ^ divisor_neg) & ~divisor_zero;
            neg_rem  <= dividend_neg;      // remainder follows dividend sign
            div_zero <= divisor_zero;
            overflow <= signed_ovf;
            sel_rem  <= op[1];
        end
    end

    // original dividend, needed for the divide by zero remainder
    always_ff @(posedge clk) begin
        if (start) begin
            dividend_hold <= dividend;
        end
    end

endmodule

//--- src/div_unit.sv
`timescale 1ns/1ps

module div_unit import div_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [OP_W-1:0]   op,
    input  logic [DATA_W-1:0] dividend,
    input  logic [DATA_W-1:0] divisor,
    output logic [DATA_W-1:0] result,
    output logic              busy,
    output logic              done
);

    logic              start_acc;
    logic [DATA_W-1:0] dividend_mag;
    logic [DATA_W-1:0] divisor_mag;
    logic              neg_quot;
    logic              neg_rem;
    logic              div_zero;
    logic              overflow;
    logic              sel_rem;
    logic [DATA_W-1:0] dividend_hold;
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;
    logic              core_done;

    // drop start while busy, busy ends with the done cycle
    assign start_acc = start & (~busy | done);

    div_sign_ctrl div_sign_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start_acc),
        .op            (op),
        .dividend      (dividend),
        .divisor       (divisor),
        .dividend_mag  (dividend_mag),
        .divisor_mag   (divisor_mag),
        .neg_quot      (neg_quot),
        .neg_rem       (neg_rem),
        .div_zero      (div_zero),
        .overflow      (overflow),
        .sel_rem       (sel_rem),
        .dividend_hold (dividend_hold)
    );

    div_core div_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start_acc),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .quotient     (quotient),
        .remainder    (remainder),
        .core_done    (core_done)
    );

    div_result div_result_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start_acc),
        .core_done     (core_done),
        .quotient      (quotient),
        .remainder     (remainder),
        .neg_quot      (neg_quot),
        .neg_rem       (neg_rem),
        .div_zero      (div_zero),
        .overflow      (overflow),
        .sel_rem       (sel_rem),
        .dividend_hold (dividend_hold),
        .result        (result),
        .busy          (busy),
        .done          (done)
    );

endmodule

//--- tb/div_golden.txt
// columns are rep op dividend divisor expected, all hex
// rep 1 sends a second start while the unit is busy, op 0 div 1 divu 2 rem 3 remu
0 1 00000064 00000007 0000000e
0 3 00000064 00000007 00000002
0 1 00000005 00000009 00000000
0 3 00000005 00000009 00000005
0 1 ffffffff ffffffff 00000001
0 3 ffffffff ffffffff 00000000
0 1 ffffffff 00000001 ffffffff
0 1 ffffffff 00000010 0fffffff
0 3 ffffffff 00000010 0000000f
0 1 80000000 00000003 2aaaaaaa
0 3 80000000 00000003 00000002
// signed, all four sign combinations
0 0 00000007 00000002 00000003
0 2 00000007 00000002 00000001
0 0 fffffff9 00000002 fffffffd
0 2 fffffff9 00000002 ffffffff
0 0 00000007 fffffffe fffffffd
0 2 00000007 fffffffe 00000001
0 0 fffffff9 fffffffe 00000003
0 2 fffffff9 fffffffe ffffffff
0 0 ffffff9c 00000007 fffffff2
0 2 ffffff9c 00000007 fffffffe
0 0 fffffffd 00000005 00000000
0 2 fffffffd 00000005 fffffffd
// divide by zero
0 0 12345678 00000000 ffffffff
0 1 12345678 00000000 ffffffff
0 2 fffffff9 00000000 fffffff9
0 3 12345678 00000000 12345678
// most negative over minus one
0 0 80000000 ffffffff 80000000
0 2 80000000 ffffffff 00000000
0 1 80000000 ffffffff 00000000
0 3 80000000 ffffffff 80000000
// start while busy
1 1 12345678 00000100 00123456
0 3 12345678 00000100 00000078

//--- tb/div_monitor.sv
`timescale 1ns/1ps

module div_monitor import div_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              busy,
    input  logic              done,
    input  logic [DATA_W-1:0] result,
    output int                err_cnt,
    output int                test_cnt
);

    logic [DATA_W-1:0] gold [0:319];
    int                n_tests = 0;
    int                errs = 0;
    int                tcnt = 0;
    int                edge_cnt = 0;
    int                start_edge = 0;
    logic              started = 1'b0;
    logic              exp_busy;
    logic              have_result = 1'b0;
    logic [DATA_W-1:0] held = '0;

    assign err_cnt  = errs;
    assign test_cnt = tcnt;

    initial begin
        for (int i = 0; i < $size(gold); i++) begin
            gold[i] = 32'hdead_0000 + i;
        end
        $readmemh("tb/div_golden.txt", gold);
        while (n_tests < $size(gold) / 5 && gold[5*n_tests] <= 1) begin
            n_tests++;
        end
    end

    // edge of the last accepted start
    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
        if (rst_n && start && (!busy || done)) begin
            start_edge = edge_cnt;
            started    = 1'b1;
        end
    end

    task automatic check_result();
        logic [DATA_W-1:0] expect_val;
        int                latency;
        logic              ok;
        latency = edge_cnt - start_edge;
        ok      = 1'b1;
        if (tcnt >= n_tests) begin
            $display("unexpected done pulse at %0t after the last test", $time);
            errs++;
        end else begin
            expect_val = gold[5*tcnt+4];
            if (result !== expect_val) begin
                $display("mismatch at %0t: result expected %h actual %h",
                         $time, expect_val, result);
                ok = 1'b0;
            end
            if (latency != DIV_LATENCY) begin
                $display("done came %0d edges after start at %0t, not %0d",
                         latency, $time, DIV_LATENCY);
                ok = 1'b0;
            end
            $display("test %0d op %0d %h / %h -> %h %s", tcnt, gold[5*tcnt+1],
                     gold[5*tcnt+2], gold[5*tcnt+3], result, ok ? "passed" : "failed");
            if (!ok) begin
                errs++;
            end
        end
        tcnt++;
        have_result = 1'b1;
        held        = result;
    endtask

    // outputs only move on rising edges
    always @(negedge clk) begin
        if (rst_n && done) begin
            check_result();
        end else if (have_result && result !== held) begin
            $display("result changed at %0t without a done pulse", $time);
            errs++;
            held = result;
        end
    end

    // busy spans the start edge up to the done cycle
    always @(negedge clk) begin
        exp_busy = started && (edge_cnt - start_edge <= DIV_LATENCY);
        if (rst_n && busy !== exp_busy) begin
            $display("mismatch at %0t: busy expected %b actual %b",
                     $time, exp_busy, busy);
            errs++;
        end
    end

endmodule

//--- tb/div_unit_checker.sv
`timescale 1ns/1ps

module div_unit_checker import div_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);

    logic start_acc;
    int   fail_cnt = 0;

    assign start_acc = start & (~busy | done);   // start is taken in the done cycle too

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_cnt++;
        end

    done_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> busy)
        else begin
            $error("done was raised while busy was low");
            fail_cnt++;
        end

    // consequent starts one edge after the start sample
    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start_acc |=> ##DIV_LATENCY done)
        else begin
            $error("done did not follow an accepted start after the fixed latency");
            fail_cnt++;
        end

    idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> !busy && !done)
        else begin
            $error("busy or done was high right after reset");
            fail_cnt++;
        end

endmodule

//--- tb/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb import div_pkg::*; ();

    logic              clk;
    logic              rst_n;
    logic              start;
    logic [OP_W-1:0]   op;
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
    logic [DATA_W-1:0] result;
    logic              busy;
    logic              done;

    logic [DATA_W-1:0] gold [0:319];   // five words per test
    int                n_tests = 0;
    int                err_cnt = 0;
    int                total_errs;
    int                mon_errs;
    int                mon_tests;

    initial clk = 1'b0;
    always #50 clk = ~clk;             // 100 ns period

    div_unit div_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .result   (result),
        .busy     (busy),
        .done     (done)
    );

    div_monitor div_monitor_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .result   (result),
        .err_cnt  (mon_errs),
        .test_cnt (mon_tests)
    );

    bind div_unit div_unit_checker div_unit_checker_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    // any first column above one ends the list
    function automatic int count_tests();
        int k;
        k = 0;
        while (k < $size(gold) / 5 && gold[5*k] <= 1) begin
            k++;
        end
        return k;
    endfunction

    task automatic load_golden();
        for (int i = 0; i < $size(gold); i++) begin
            gold[i] = 32'hdead_0000 + i;
        end
        $readmemh("tb/div_golden.txt", gold);
        n_tests = count_tests();
    endtask

    // runs from a falling edge up to the falling edge that sees done
    task automatic run_test(input int idx);
        logic rep;
        rep      = gold[5*idx][0];
        op       = gold[5*idx+1][OP_W-1:0];
        dividend = gold[5*idx+2];
        divisor  = gold[5*idx+3];
        start    = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        if (rep) begin
            repeat (4) @(negedge clk);
            op       = ~op;            // a different request that must be dropped
            dividend = ~dividend;
            divisor  = divisor + 32'd1;
            start    = 1'b1;
            @(negedge clk);
            start    = 1'b0;
        end
        while (!done) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        op       = '0;
        dividend = '0;
        divisor  = '0;
        load_golden();
        if (n_tests == 0) begin
            $display("no tests found in tb/div_golden.txt");
            err_cnt++;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        repeat (5) @(negedge clk);     // room for a stray done
        if (mon_tests != n_tests) begin
            $display("expected %0d done pulses but saw %0d", n_tests, mon_tests);
            err_cnt++;
        end
        total_errs = err_cnt + mon_errs + div_unit_i.div_unit_checker_i.fail_cnt;
        $display("tests %0d  done pulses %0d  errors %0d",
                 n_tests, mon_tests, total_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog sized from the number of tests
    initial begin
        wait (n_tests != 0);
        repeat (n_tests * (DIV_LATENCY + 4) + 10) @(posedge clk);
        $display("timeout at %0t, the divide unit did not finish all tests", $time);
        $display("Finished with errors");
        $finish;
    end

endmodule
